//--- Makefile
TOP = tb_maind

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f maind_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f maind_top.f
	-./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended early, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- maind_top.f
rtl/maind_pkg.sv
rtl/sys_timing.sv
rtl/trig_receiver.sv
rtl/csr_axil.sv
rtl/led_engine.sv
rtl/led_bank.sv
rtl/maind_top.sv
verification/maind_props.sv
verification/tb_maind.sv

//--- rtl/csr_axil.sv
`timescale 1ns/1ns

module csr_axil (
	input  logic CLK125,
	input  logic reset_i,
	input  maind_pkg::axil_req_t axil_req_i,
	output maind_pkg::axil_rsp_t axil_rsp_o,
	input  maind_pkg::token_t token_i,
	output maind_pkg::csr_ctrl_t ctrl_o,
	output logic access_o
);

	logic wr_acc;
	logic rd_acc;
	logic wr_ok;
	logic bvalid_q;
	logic rvalid_q;
	logic [1:0] bresp_q;
	logic [1:0] rresp_q;
	logic [maind_pkg::AXIL_DATA_W-1:0] rdata_q;
	logic [maind_pkg::AXIL_DATA_W-1:0] rd_data;
	logic [1:0] rd_resp;
	// Last token, err on top
	logic [maind_pkg::TOKEN_W:0] status_q;
	maind_pkg::csr_ctrl_t ctrl_q;
	logic access_q;

	////////////////////////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////////////////////////

	// Address and data together, only with no pending response
	assign wr_acc = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
	assign rd_acc = axil_req_i.arvalid & ~rvalid_q;

	// Only CONTROL takes writes
	assign wr_ok = (axil_req_i.awaddr == maind_pkg::CSR_CONTROL);

	// Read decode
	always_comb begin
		rd_data = '0;
		rd_resp = maind_pkg::RESP_OKAY;
		case (axil_req_i.araddr)
			maind_pkg::CSR_CONTROL: begin
				rd_data[0] = ctrl_q.clk_sel;
				rd_data[1] = ctrl_q.inhibit;
				rd_data[2] = ctrl_q.test_pulse;
			end
			maind_pkg::CSR_STATUS: begin
				rd_data[maind_pkg::TOKEN_W:0] = status_q;
			end
			maind_pkg::CSR_VERSION: begin
				rd_data = maind_pkg::VERSION_WORD;
			end
			default: begin
				// Unmapped, zero data
				rd_resp = maind_pkg::RESP_SLVERR;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			ctrl_q <= '0;
			status_q <= '0;
			access_q <= 1'b0;
		end else begin
			// Write response held until bready
			if (wr_acc) begin
				bvalid_q <= 1'b1;
			end else if (axil_req_i.bready) begin
				bvalid_q <= 1'b0;
			end
			// Read response held until rready
			if (rd_acc) begin
				rvalid_q <= 1'b1;
			end else if (axil_req_i.rready) begin
				rvalid_q <= 1'b0;
			end
			if (wr_acc && wr_ok) begin
				ctrl_q.clk_sel <= axil_req_i.wdata[0];
				ctrl_q.inhibit <= axil_req_i.wdata[1];
				ctrl_q.test_pulse <= axil_req_i.wdata[2];
			end
			// Latch every received token
			if (token_i.rdy) begin
				status_q <= {token_i.err, token_i.value};
			end
			// One pulse per accepted transaction, for the LED
			access_q <= wr_acc | rd_acc;
		end
	end

	// Response payload
	always_ff @(posedge CLK125) begin
		if (wr_acc) begin
			bresp_q <= wr_ok ? maind_pkg::RESP_OKAY : maind_pkg::RESP_SLVERR;
		end
		if (rd_acc) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////
	always_comb begin
		axil_rsp_o.awready = wr_acc;
		axil_rsp_o.wready = wr_acc;
		axil_rsp_o.bresp = bresp_q;
		axil_rsp_o.bvalid = bvalid_q;
		axil_rsp_o.arready = rd_acc;
		axil_rsp_o.rdata = rdata_q;
		axil_rsp_o.rresp = rresp_q;
		axil_rsp_o.rvalid = rvalid_q;
	end

	assign ctrl_o = ctrl_q;
	assign access_o = access_q;

endmodule

//--- rtl/led_bank.sv
`timescale 1ns/1ns

module led_bank #(
	parameter int unsigned STRETCH_CYCLES = 12500000
) (
	input  logic CLK125,
	input  logic reset_i,
	input  logic sys_rst_i,
	input  maind_pkg::token_t token_i,
	input  logic access_i,
	input  maind_pkg::csr_ctrl_t ctrl_i,
	output logic [3:0] led_o
);

	logic [3:0] ledp;

	////////////////////////////////////////////////////////////
	// Indicator sources
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			ledp <= '0;
		end else begin
			// Yellow, global reset or bad token
			ledp[0] <= sys_rst_i | (token_i.rdy & token_i.err);
			// Register bus access
			ledp[1] <= access_i;
			// Master trigger received
			ledp[2] <= token_i.rdy;
			// No inhibit
			ledp[3] <= ~ctrl_i.inhibit;
		end
	end

	// One stretcher per LED
	for (genvar i = 0; i < 4; i++) begin : g_led
		led_engine #(
			.STRETCH_CYCLES(STRETCH_CYCLES)
		) i_led_engine (
			.CLK125(CLK125),
			.reset_i(reset_i),
			.trig_i(ledp[i]),
			.led_o(led_o[i])
		);
	end

endmodule

//--- rtl/led_engine.sv
`timescale 1ns/1ns

module led_engine #(
	parameter int unsigned STRETCH_CYCLES = 12500000
) (
	input  logic CLK125,
	input  logic reset_i,
	input  logic trig_i,
	output logic led_o
);

	localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

	logic [CNT_W-1:0] on_cnt;

	// Reload on every trigger, count out otherwise
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			on_cnt <= '0;
		end else if (trig_i) begin
			on_cnt <= CNT_W'(STRETCH_CYCLES);
		end else if (on_cnt != '0) begin
			on_cnt <= on_cnt - 1'b1;
		end
	end

	// Lit while time remains
	assign led_o = (on_cnt != '0);

endmodule

//--- rtl/maind_pkg.sv
package maind_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Trigger token carried on the serial line
	localparam int TOKEN_W = 10;
	// Status word back over the serial links
	localparam int LINK_W = 16;
	// Register bus
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;

	////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////

	// Comma sent when no token goes out
	localparam logic [LINK_W-1:0] LINK_IDLE = 16'h00BC;

	// Register byte offsets
	localparam logic [AXIL_ADDR_W-1:0] CSR_CONTROL = 4'h0;
	localparam logic [AXIL_ADDR_W-1:0] CSR_STATUS = 4'h4;
	localparam logic [AXIL_ADDR_W-1:0] CSR_VERSION = 4'h8;

	// Design version readback
	localparam logic [AXIL_DATA_W-1:0] VERSION_WORD = 32'h0125_0102;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////

	// Received token with its receipt strobe
	typedef struct packed {
		logic rdy;
		logic err;
		logic [TOKEN_W-1:0] value;
	} token_t;

	// Control register fields
	typedef struct packed {
		logic clk_sel;
		logic inhibit;
		logic test_pulse;
	} csr_ctrl_t;

	// Master to slave
	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic awvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic wvalid;
		logic bready;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// Slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

endpackage

//--- rtl/maind_top.sv
`timescale 1ns/1ns

module maind_top #(
	// Power-up holdoff, 8 ms at 125 MHz
	parameter int unsigned HOLDOFF_CYCLES = 1000000,
	// LED on-time, 100 ms
	parameter int unsigned STRETCH_CYCLES = 12500000
) (
	input  logic CLK125,
	input  logic reset_i,
	input  logic ext_reset_n_i,
	input  logic ser_trig_i,
	input  maind_pkg::axil_req_t axil_req_i,
	output maind_pkg::axil_rsp_t axil_rsp_o,
	output logic [maind_pkg::LINK_W-1:0] link_word_o,
	output logic link_kchar_o,
	output logic sync_o,
	output logic sys_rst_o,
	output logic clk_sel_o,
	output logic inhibit_o,
	output logic test_pulse_o,
	output logic [3:0] led_o
);

	logic sys_rst;
	logic access;
	maind_pkg::token_t token;
	maind_pkg::csr_ctrl_t ctrl;

	////////////////////////////////////////////////////////////
	// Reset and sync
	////////////////////////////////////////////////////////////
	sys_timing #(
		.HOLDOFF_CYCLES(HOLDOFF_CYCLES)
	) i_sys_timing (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.ext_reset_n_i(ext_reset_n_i),
		.ctrl_i(ctrl),
		.sys_rst_o(sys_rst),
		.sync_o(sync_o)
	);

	// Serial trigger in, status word out
	trig_receiver i_trig_receiver (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.ser_trig_i(ser_trig_i),
		.token_o(token),
		.link_word_o(link_word_o),
		.link_kchar_o(link_kchar_o)
	);

	// Register block
	csr_axil i_csr_axil (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.axil_req_i(axil_req_i),
		.axil_rsp_o(axil_rsp_o),
		.token_i(token),
		.ctrl_o(ctrl),
		.access_o(access)
	);

	// Front panel
	led_bank #(
		.STRETCH_CYCLES(STRETCH_CYCLES)
	) i_led_bank (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.sys_rst_i(sys_rst),
		.token_i(token),
		.access_i(access),
		.ctrl_i(ctrl),
		.led_o(led_o)
	);

	assign sys_rst_o = sys_rst;
	// Clock mux and channel controls
	assign clk_sel_o = ctrl.clk_sel;
	assign inhibit_o = ctrl.inhibit;
	assign test_pulse_o = ctrl.test_pulse;

endmodule

//--- rtl/sys_timing.sv
`timescale 1ns/1ns

module sys_timing #(
	parameter int unsigned HOLDOFF_CYCLES = 1000000
) (
	input  logic CLK125,
	input  logic reset_i,
	input  logic ext_reset_n_i,
	input  maind_pkg::csr_ctrl_t ctrl_i,
	output logic sys_rst_o,
	output logic sync_o
);

	// Wide enough to hold the terminal count
	localparam int HOLD_W = $clog2(HOLDOFF_CYCLES + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic hold_done;
	logic [2:0] div_cnt;

	// Counter parks on its last value
	assign hold_done = (hold_cnt == HOLD_W'(HOLDOFF_CYCLES - 1));

	////////////////////////////////////////////////////////////
	// Power-up holdoff, then external reset line
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			hold_cnt <= '0;
			sys_rst_o <= 1'b1;
		end else if (!hold_done) begin
			hold_cnt <= hold_cnt + 1'b1;
			sys_rst_o <= 1'b1;
		end else begin
			// Line is active low
			sys_rst_o <= ~ext_reset_n_i;
		end
	end

	////////////////////////////////////////////////////////////
	// 125/8 MHz sync wave
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			div_cnt <= '0;
			sync_o <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			// Blanked while inhibit set
			sync_o <= div_cnt[2] & ~ctrl_i.inhibit;
		end
	end

endmodule

//--- rtl/trig_receiver.sv
`timescale 1ns/1ns

module trig_receiver (
	input  logic CLK125,
	input  logic reset_i,
	input  logic ser_trig_i,
	output maind_pkg::token_t token_o,
	output logic [maind_pkg::LINK_W-1:0] link_word_o,
	output logic link_kchar_o
);

	// Bit index 0 to TOKEN_W, the last one is parity
	localparam int CNT_W = $clog2(maind_pkg::TOKEN_W + 1);
	localparam logic [CNT_W-1:0] PAR_IDX = CNT_W'(maind_pkg::TOKEN_W);

	logic busy;
	logic [CNT_W-1:0] bit_cnt;
	logic [maind_pkg::TOKEN_W-1:0] shift_q;
	logic par_bit;
	maind_pkg::token_t token_q;

	// Sampling the parity bit in this cycle
	assign par_bit = busy && (bit_cnt == PAR_IDX);

	////////////////////////////////////////////////////////////
	// Frame control
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			token_q <= '0;
		end else begin
			// Strobe lasts one cycle
			token_q.rdy <= 1'b0;
			if (!busy) begin
				// Idle low, start bit is high
				if (ser_trig_i) begin
					busy <= 1'b1;
					bit_cnt <= '0;
				end
			end else if (par_bit) begin
				busy <= 1'b0;
				token_q.rdy <= 1'b1;
				token_q.value <= shift_q;
				// Odd parity expected over data and parity
				token_q.err <= ~(^{shift_q, ser_trig_i});
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Data bits, MSB first
	always_ff @(posedge CLK125) begin
		if (busy && !par_bit) begin
			shift_q <= {shift_q[maind_pkg::TOKEN_W-2:0], ser_trig_i};
		end
	end

	assign token_o = token_q;

	////////////////////////////////////////////////////////////
	// Return link word
	////////////////////////////////////////////////////////////

	// Token with status when one arrives, comma otherwise
	assign link_word_o = token_q.rdy ? {5'b10000, token_q.err, token_q.value}
		: maind_pkg::LINK_IDLE;
	// Data word is not a K character
	assign link_kchar_o = ~token_q.rdy;

endmodule

//--- verification/maind_props.sv
`timescale 1ns/1ns

module maind_props (
	input logic CLK125,
	input logic reset_i,
	input maind_pkg::axil_req_t req_i,
	input maind_pkg::axil_rsp_t rsp_i,
	input logic kchar_i
);

	////////////////////////////////////////////////////////////
	// AXI4-Lite response channels
	////////////////////////////////////////////////////////////

	// Write response waits for bready
	bvalid_hold: assert property (@(posedge CLK125) disable iff (reset_i)
		rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
		else $error("bvalid dropped before bready");

	// Read response waits for rready
	rvalid_hold: assert property (@(posedge CLK125) disable iff (reset_i)
		rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid)
		else $error("rvalid dropped before rready");

	// Payload frozen while stalled
	rdata_stable: assert property (@(posedge CLK125) disable iff (reset_i)
		rsp_i.rvalid && !req_i.rready |=> $stable(rsp_i.rdata) && $stable(rsp_i.rresp))
		else $error("rdata or rresp changed while rvalid waited");

	// Token word is a single cycle, comma otherwise
	kchar_gap: assert property (@(posedge CLK125) disable iff (reset_i)
		!kchar_i |=> kchar_i)
		else $error("link_kchar_o low for more than one cycle");

endmodule

bind maind_top maind_props i_maind_props (
	.CLK125(CLK125),
	.reset_i(reset_i),
	.req_i(axil_req_i),
	.rsp_i(axil_rsp_o),
	.kchar_i(link_kchar_o)
);

//--- verification/tb_maind.sv
`timescale 1ns/1ns

module tb_maind;

	localparam int HOLDOFF = 64;
	localparam int STRETCH = 16;
	localparam int FRAMES = 200;
	localparam int AXI_LIMIT = 16;
	// Frames of up to 13 cycles plus the register and reset tests
	localparam int WATCHDOG_NS = (FRAMES * 13 + 2000) * 8;

	logic CLK125;
	logic reset_i;
	logic ext_reset_n_i;
	logic ser_trig_i;
	maind_pkg::axil_req_t axil_req;
	maind_pkg::axil_rsp_t axil_rsp;
	logic [maind_pkg::LINK_W-1:0] link_word_o;
	logic link_kchar_o;
	logic sync_o;
	logic sys_rst_o;
	logic clk_sel_o;
	logic inhibit_o;
	logic test_pulse_o;
	logic [3:0] led_o;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errs_before = 0;
	string test_name = "reset_state";
	logic [31:0] lfsr = 32'ha3d2;
	// High for the cycle that carries a parity bit
	logic par_mark;
	// Link words still due from the receiver
	logic [maind_pkg::LINK_W-1:0] exp_q[$];

	maind_top #(
		.HOLDOFF_CYCLES(HOLDOFF),
		.STRETCH_CYCLES(STRETCH)
	) i_dut (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.ext_reset_n_i(ext_reset_n_i),
		.ser_trig_i(ser_trig_i),
		.axil_req_i(axil_req),
		.axil_rsp_o(axil_rsp),
		.link_word_o(link_word_o),
		.link_kchar_o(link_kchar_o),
		.sync_o(sync_o),
		.sys_rst_o(sys_rst_o),
		.clk_sel_o(clk_sel_o),
		.inhibit_o(inhibit_o),
		.test_pulse_o(test_pulse_o),
		.led_o(led_o)
	);

	// 125 MHz
	initial begin
		CLK125 = 1'b0;
		forever #4 CLK125 = ~CLK125;
	end

	////////////////////////////////////////////////////////////
	// Random source and reference models
	////////////////////////////////////////////////////////////

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	// Header 10000, error flag, token
	function automatic logic [15:0] link_ref(input logic [9:0] value, input logic err);
		return {5'b10000, err, value};
	endfunction

	// Response code on top of read data
	function automatic logic [33:0] read_ref(input logic [3:0] addr, input logic [2:0] ctrl,
		input logic [10:0] status);
		case (addr)
			maind_pkg::CSR_CONTROL: return {maind_pkg::RESP_OKAY, 29'd0, ctrl};
			maind_pkg::CSR_STATUS: return {maind_pkg::RESP_OKAY, 21'd0, status};
			maind_pkg::CSR_VERSION: return {maind_pkg::RESP_OKAY, maind_pkg::VERSION_WORD};
			default: return {maind_pkg::RESP_SLVERR, 32'd0};
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Checks and bookkeeping
	////////////////////////////////////////////////////////////
	task automatic expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			$display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic finish_test(input string next_name);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %-18s ok", test_name);
		end else begin
			tests_failed++;
			$display("test %-18s failed, %0d errors", test_name, errors - errs_before);
		end
		errs_before = errors;
		test_name = next_name;
	endtask

	////////////////////////////////////////////////////////////
	// Serial trigger driver
	////////////////////////////////////////////////////////////
	task automatic drive_bit(input logic b, input logic mark);
		@(posedge CLK125);
		ser_trig_i <= b;
		par_mark <= mark;
	endtask

	// Start bit, token MSB first, parity
	task automatic send_frame(input logic [9:0] value, input logic bad);
		logic par;
		par = ~(^value) ^ bad;
		drive_bit(1'b1, 1'b0);
		for (int k = 9; k >= 0; k--) begin
			drive_bit(value[k], 1'b0);
		end
		drive_bit(par, 1'b1);
		exp_q.push_back(link_ref(value, bad));
	endtask

	////////////////////////////////////////////////////////////
	// AXI4-Lite master
	////////////////////////////////////////////////////////////
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		n = 0;
		@(posedge CLK125);
		axil_req.awaddr <= addr;
		axil_req.wdata <= data;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid <= 1'b1;
		do begin
			@(negedge CLK125);
			n++;
		end while (!axil_rsp.awready && n < AXI_LIMIT);
		assert (axil_rsp.awready === 1'b1) else begin
			$display("ERROR write to %0h was never accepted", addr);
			errors++;
		end
		// Data channel taken in the same cycle
		expect_eq("wready", 64'(1), 64'(axil_rsp.wready));
		@(posedge CLK125);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge CLK125);
			n++;
		end while (!axil_rsp.bvalid && n < AXI_LIMIT);
		assert (axil_rsp.bvalid === 1'b1) else begin
			$display("ERROR write to %0h got no response", addr);
			errors++;
		end
		resp = axil_rsp.bresp;
		// Hold bready off one cycle
		@(posedge CLK125);
		axil_req.bready <= 1'b1;
		@(posedge CLK125);
		axil_req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		n = 0;
		@(posedge CLK125);
		axil_req.araddr <= addr;
		axil_req.arvalid <= 1'b1;
		do begin
			@(negedge CLK125);
			n++;
		end while (!axil_rsp.arready && n < AXI_LIMIT);
		assert (axil_rsp.arready === 1'b1) else begin
			$display("ERROR read of %0h was never accepted", addr);
			errors++;
		end
		@(posedge CLK125);
		axil_req.arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge CLK125);
			n++;
		end while (!axil_rsp.rvalid && n < AXI_LIMIT);
		assert (axil_rsp.rvalid === 1'b1) else begin
			$display("ERROR read of %0h got no response", addr);
			errors++;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge CLK125);
		axil_req.rready <= 1'b1;
		@(posedge CLK125);
		axil_req.rready <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Link word comparator, every cycle
	////////////////////////////////////////////////////////////
	initial begin
		logic due;
		due = 1'b0;
		@(posedge CLK125);
		forever begin
			@(negedge CLK125);
			if (due) begin
				assert (exp_q.size() > 0) else begin
					$display("ERROR link word due but no token was sent");
					errors++;
				end
				if (exp_q.size() > 0) begin
					expect_eq("link_word", 64'(exp_q.pop_front()), 64'(link_word_o));
				end
				expect_eq("link_kchar", 64'(0), 64'(link_kchar_o));
			end else begin
				expect_eq("link_idle", 64'(maind_pkg::LINK_IDLE), 64'(link_word_o));
				expect_eq("link_kchar", 64'(1), 64'(link_kchar_o));
			end
			// Token word lands one cycle after the parity bit
			due = par_mark;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		int n;
		int i;
		int hi;
		int lo;
		int led_first;
		logic [1:0] resp;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [2:0] ctrl_model;
		logic [10:0] status_model;
		logic [9:0] value;
		logic bad;
		logic [3:0] addr;

		reset_i = 1'b1;
		ext_reset_n_i = 1'b1;
		ser_trig_i = 1'b0;
		par_mark = 1'b0;
		axil_req = '0;
		ctrl_model = '0;
		status_model = '0;

		// Reset values while reset is held
		repeat (4) @(posedge CLK125);
		@(negedge CLK125);
		expect_eq("sys_rst", 64'(1), 64'(sys_rst_o));
		expect_eq("controls", 64'(0), 64'({test_pulse_o, inhibit_o, clk_sel_o}));
		expect_eq("leds", 64'(0), 64'(led_o));
		@(posedge CLK125);
		reset_i <= 1'b0;

		// Count cycles of holdoff, note first LED0
		n = 0;
		led_first = 0;
		@(negedge CLK125);
		while (sys_rst_o === 1'b1 && n < 4 * HOLDOFF) begin
			@(negedge CLK125);
			n++;
			if (led_o[0] && led_first == 0) begin
				led_first = n;
			end
		end
		assert (led_first >= 1 && led_first <= 2) else begin
			$display("ERROR LED0 did not light within 2 cycles of reset release");
			errors++;
		end
		finish_test("holdoff_ext_reset");
		expect_eq("holdoff_cycles", 64'(HOLDOFF), 64'(n));

		// External line, one cycle late
		@(posedge CLK125);
		ext_reset_n_i <= 1'b0;
		@(negedge CLK125);
		expect_eq("ext_assert_before", 64'(0), 64'(sys_rst_o));
		@(negedge CLK125);
		expect_eq("ext_assert_after", 64'(1), 64'(sys_rst_o));
		@(posedge CLK125);
		ext_reset_n_i <= 1'b1;
		@(negedge CLK125);
		expect_eq("ext_release_before", 64'(1), 64'(sys_rst_o));
		@(negedge CLK125);
		expect_eq("ext_release_after", 64'(0), 64'(sys_rst_o));
		finish_test("registers");

		// No bus access yet, access LED dark
		expect_eq("led1_idle", 64'(0), 64'(led_o[1]));

		// Random CONTROL writes
		for (i = 0; i < 8; i++) begin
			wdata = rand_bits(32);
			axil_write(maind_pkg::CSR_CONTROL, wdata, resp);
			expect_eq("control_bresp", 64'(maind_pkg::RESP_OKAY), 64'(resp));
			ctrl_model = wdata[2:0];
			expect_eq("control_outputs", 64'(ctrl_model),
				64'({test_pulse_o, inhibit_o, clk_sel_o}));
			if (i == 0) begin
				// Access LED two cycles behind the access pulse
				@(negedge CLK125);
				expect_eq("led1_access", 64'(1), 64'(led_o[1]));
			end
			axil_read(maind_pkg::CSR_CONTROL, rdata, resp);
			expect_eq("control_readback",
				64'(read_ref(maind_pkg::CSR_CONTROL, ctrl_model, status_model)),
				64'({resp, rdata}));
		end
		// Whole map, offset C unmapped
		for (i = 0; i < 4; i++) begin
			addr = 4'(i * 4);
			axil_read(addr, rdata, resp);
			expect_eq("read_map", 64'(read_ref(addr, ctrl_model, status_model)),
				64'({resp, rdata}));
		end
		// Read-only and unmapped writes
		for (i = 1; i < 4; i++) begin
			addr = 4'(i * 4);
			axil_write(addr, rand_bits(32), resp);
			expect_eq("illegal_bresp", 64'(maind_pkg::RESP_SLVERR), 64'(resp));
		end
		axil_read(maind_pkg::CSR_CONTROL, rdata, resp);
		expect_eq("control_unchanged",
			64'(read_ref(maind_pkg::CSR_CONTROL, ctrl_model, status_model)),
			64'({resp, rdata}));
		finish_test("token_rx");

		for (i = 0; i < FRAMES; i++) begin
			value = 10'(rand_bits(10));
			// About one frame in eight with wrong parity
			bad = (rand_bits(3) == 32'd0);
			send_frame(value, bad);
			status_model = {bad, value};
			if (i == 0) begin
				// LED2 two cycles behind rdy
				drive_bit(1'b0, 1'b0);
				@(negedge CLK125);
				expect_eq("led2_at_rdy", 64'(0), 64'(led_o[2]));
				@(negedge CLK125);
				expect_eq("led2_next", 64'(0), 64'(led_o[2]));
				@(negedge CLK125);
				expect_eq("led2_lit", 64'(1), 64'(led_o[2]));
			end else if (rand_bits(1) != 32'd0) begin
				drive_bit(1'b0, 1'b0);
			end
		end
		drive_bit(1'b0, 1'b0);
		repeat (3) @(negedge CLK125);
		assert (exp_q.size() == 0) else begin
			$display("ERROR %0d tokens produced no link word", exp_q.size());
			errors++;
		end
		axil_read(maind_pkg::CSR_STATUS, rdata, resp);
		expect_eq("status_last_token",
			64'(read_ref(maind_pkg::CSR_STATUS, ctrl_model, status_model)),
			64'({resp, rdata}));
		finish_test("sync_inhibit");

		axil_write(maind_pkg::CSR_CONTROL, 32'h0, resp);
		ctrl_model = '0;
		// Find a rising edge of sync
		n = 0;
		@(negedge CLK125);
		while (sync_o === 1'b1 && n < 16) begin
			@(negedge CLK125);
			n++;
		end
		while (sync_o === 1'b0 && n < 16) begin
			@(negedge CLK125);
			n++;
		end
		hi = 0;
		while (sync_o === 1'b1 && hi < 16) begin
			@(negedge CLK125);
			hi++;
		end
		lo = 0;
		while (sync_o === 1'b0 && lo < 16) begin
			@(negedge CLK125);
			lo++;
		end
		expect_eq("sync_high", 64'(4), 64'(hi));
		expect_eq("sync_low", 64'(4), 64'(lo));

		// Inhibit blanks sync and LED3
		axil_write(maind_pkg::CSR_CONTROL, 32'h2, resp);
		expect_eq("inhibit_out", 64'(1), 64'(inhibit_o));
		for (i = 0; i < STRETCH + 4; i++) begin
			@(negedge CLK125);
			expect_eq("sync_blanked", 64'(0), 64'(sync_o));
		end
		expect_eq("led3_dark", 64'(0), 64'(led_o[3]));
		finish_test("done");

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
